//--- Bender.yml
package:
  name: aesCore

sources:
  - files:
      - rtl/aesPkg.sv
      - rtl/apbPkg.sv
      - rtl/aesApbRegs.sv
      - rtl/aesKeySchedule.sv
      - rtl/aesRoundEngine.sv
      - rtl/aesCore.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/aesCoreTb.sv

//--- aesCore.f
+incdir+tests
rtl/aesPkg.sv
rtl/apbPkg.sv
rtl/aesApbRegs.sv
rtl/aesKeySchedule.sv
rtl/aesRoundEngine.sv
rtl/aesCore.sv
tests/aesCoreTb.sv

//--- rtl/aesApbRegs.sv
`timescale 1ns/10ps
`default_nettype none

module aesApbRegs (
	input logic clock,
	input logic reset,
	input apbPkg::apbReq apbReq,
	output apbPkg::apbRsp apbRsp,
	output logic start,
	output logic decrypt,
	output aesPkg::aesKey cipherKey,
	output aesPkg::aesBlock dataIn,
	input logic blockDone,
	input aesPkg::aesBlock dataOut,
	output logic done
);
	import apbPkg::*;
	import aesPkg::*;

	logic access;
	logic aligned;
	logic isKey;
	logic isData;
	logic isResult;
	logic isCtrl;
	logic isStatus;
	logic slvErr;
	logic writeOk;
	logic busy;
	logic [1:0] word;
	apbData readData;
	aesBlock resultReg;

	assign access = apbReq.psel & apbReq.penable;
	assign aligned = apbReq.paddr[1:0] == 2'b00;
	assign word = apbReq.paddr[3:2];

	assign isKey = aligned && apbReq.paddr[7:4] == keyBase[7:4];
	assign isData = aligned && apbReq.paddr[7:4] == dataBase[7:4];
	assign isResult = aligned && apbReq.paddr[7:4] == resultBase[7:4];
	assign isCtrl = apbReq.paddr == ctrlAddr;
	assign isStatus = apbReq.paddr == statusAddr;

	// Unmapped, read-only, or a write while a block is in flight
	assign slvErr = access && (!(isKey || isData || isResult || isCtrl || isStatus)
		|| (apbReq.pwrite && (isResult || isStatus || busy)));
	assign writeOk = access && apbReq.pwrite && !slvErr;

	always_comb
	begin
		readData = '0;
		if (isKey)
		begin
			readData = cipherKey[4 * word +: 4];
		end
		else if (isData)
		begin
			readData = dataIn[4 * word +: 4];
		end
		else if (isResult)
		begin
			readData = resultReg[4 * word +: 4];
		end
		else if (isCtrl)
		begin
			readData[ctrlDecryptBit] = decrypt;
		end
		else if (isStatus)
		begin
			readData[statusBusyBit] = busy;
			readData[statusDoneBit] = done;
		end
	end

	assign apbRsp = '{prdata: readData, pready: 1'b1, pslverr: slvErr};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			start <= 1'b0;
			decrypt <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			resultReg <= '0;
		end
		else
		begin
			start <= writeOk && isCtrl && apbReq.pwdata[ctrlStartBit];
			if (writeOk && isCtrl)
			begin
				decrypt <= apbReq.pwdata[ctrlDecryptBit];
			end
			if (writeOk && isCtrl && apbReq.pwdata[ctrlStartBit])
			begin
				busy <= 1'b1;
				done <= 1'b0;
			end
			else if (blockDone)
			begin
				busy <= 1'b0;
				done <= 1'b1;
				resultReg <= dataOut;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (writeOk && isKey)
		begin
			cipherKey[4 * word +: 4] <= apbReq.pwdata;
		end
		if (writeOk && isData)
		begin
			dataIn[4 * word +: 4] <= apbReq.pwdata;
		end
	end

endmodule

`default_nettype wire

//--- rtl/aesCore.sv
`timescale 1ns/10ps
`default_nettype none

module aesCore (
	input logic clock,
	input logic reset,
	input apbPkg::apbReq apbReq,
	output apbPkg::apbRsp apbRsp,
	output logic done
);
	import aesPkg::*;

	logic start;
	logic decrypt;
	logic keysReady;
	logic blockDone;
	aesKey cipherKey;
	aesKey roundKey;
	aesBlock dataIn;
	aesBlock dataOut;
	roundIndex keyIndex;

	aesApbRegs apbRegs (
		.clock(clock),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.start(start),
		.decrypt(decrypt),
		.cipherKey(cipherKey),
		.dataIn(dataIn),
		.blockDone(blockDone),
		.dataOut(dataOut),
		.done(done)
	);

	aesKeySchedule keySchedule (
		.clock(clock),
		.reset(reset),
		.start(start),
		.cipherKey(cipherKey),
		.keyIndex(keyIndex),
		.roundKey(roundKey),
		.keysReady(keysReady)
	);

	aesRoundEngine roundEngine (
		.clock(clock),
		.reset(reset),
		.keysReady(keysReady),
		.decrypt(decrypt),
		.dataIn(dataIn),
		.roundKey(roundKey),
		.keyIndex(keyIndex),
		.dataOut(dataOut),
		.blockDone(blockDone)
	);

endmodule

`default_nettype wire

//--- rtl/aesKeySchedule.sv
`timescale 1ns/10ps
`default_nettype none

module aesKeySchedule (
	input logic clock,
	input logic reset,
	input logic start,
	input aesPkg::aesKey cipherKey,
	input aesPkg::roundIndex keyIndex,
	output aesPkg::aesKey roundKey,
	output logic keysReady
);
	import aesPkg::*;

	aesKey roundKeys [0:numRounds];
	roundIndex keyCount;
	logic [7:0] rcon;
	logic expanding;

	// Keys 0 and 1 land together, then one key per cycle up to key 10
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			expanding <= 1'b0;
			keyCount <= '0;
			rcon <= 8'h01;
			keysReady <= 1'b0;
		end
		else
		begin
			keysReady <= 1'b0;
			if (start)
			begin
				expanding <= 1'b1;
				keyCount <= 4'd2;
				rcon <= 8'h02;
			end
			else if (expanding)
			begin
				keyCount <= keyCount + 1'b1;
				rcon <= gfDouble(rcon);
				if (keyCount == numRounds)
				begin
					expanding <= 1'b0;
					keysReady <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (start)
		begin
			roundKeys[0] <= cipherKey;
			roundKeys[1] <= nextRoundKey(cipherKey, 8'h01);
		end
		else if (expanding)
		begin
			roundKeys[keyCount] <= nextRoundKey(roundKeys[keyCount - 1'b1], rcon);
		end
	end

	assign roundKey = roundKeys[keyIndex];

endmodule

`default_nettype wire

//--- rtl/aesPkg.sv
`default_nettype none

package aesPkg;

	// Byte 0 is the most significant, bytes run down each column
	typedef logic [0:15][7:0] aesBlock;
	typedef logic [0:15][7:0] aesKey;
	typedef logic [3:0] roundIndex;

	localparam int numRounds = 10;

	localparam logic [0:255][7:0] sBox = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] invSBox = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	// Multiply by x modulo the AES polynomial
	function automatic logic [7:0] gfDouble(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic aesBlock subBytes(input aesBlock s);
		aesBlock r;
		for (int i = 0; i < 16; i++)
		begin
			r[i] = sBox[s[i]];
		end
		return r;
	endfunction

	function automatic aesBlock invSubBytes(input aesBlock s);
		aesBlock r;
		for (int i = 0; i < 16; i++)
		begin
			r[i] = invSBox[s[i]];
		end
		return r;
	endfunction

	// Row n rotates left by n columns
	function automatic aesBlock shiftRows(input aesBlock s);
		aesBlock r;
		for (int c = 0; c < 4; c++)
		begin
			for (int row = 0; row < 4; row++)
			begin
				r[4 * c + row] = s[4 * ((c + row) % 4) + row];
			end
		end
		return r;
	endfunction

	function automatic aesBlock invShiftRows(input aesBlock s);
		aesBlock r;
		for (int c = 0; c < 4; c++)
		begin
			for (int row = 0; row < 4; row++)
			begin
				r[4 * c + row] = s[4 * ((c - row + 4) % 4) + row];
			end
		end
		return r;
	endfunction

	function automatic aesBlock mixColumns(input aesBlock s);
		aesBlock r;
		logic [7:0] a [4];
		logic [7:0] x2 [4];
		for (int c = 0; c < 4; c++)
		begin
			for (int i = 0; i < 4; i++)
			begin
				a[i] = s[4 * c + i];
				x2[i] = gfDouble(a[i]);
			end
			// 2*a0 ^ 3*a1 ^ a2 ^ a3, rotated per row
			for (int i = 0; i < 4; i++)
			begin
				r[4 * c + i] = x2[i] ^ x2[(i + 1) % 4] ^ a[(i + 1) % 4]
					^ a[(i + 2) % 4] ^ a[(i + 3) % 4];
			end
		end
		return r;
	endfunction

	function automatic aesBlock invMixColumns(input aesBlock s);
		aesBlock r;
		logic [7:0] a;
		logic [7:0] x2;
		logic [7:0] x4;
		logic [7:0] x8;
		logic [7:0] m9 [4];
		logic [7:0] m11 [4];
		logic [7:0] m13 [4];
		logic [7:0] m14 [4];
		for (int c = 0; c < 4; c++)
		begin
			for (int i = 0; i < 4; i++)
			begin
				a = s[4 * c + i];
				x2 = gfDouble(a);
				x4 = gfDouble(x2);
				x8 = gfDouble(x4);
				m9[i] = x8 ^ a;
				m11[i] = x8 ^ x2 ^ a;
				m13[i] = x8 ^ x4 ^ a;
				m14[i] = x8 ^ x4 ^ x2;
			end
			for (int i = 0; i < 4; i++)
			begin
				r[4 * c + i] = m14[i] ^ m11[(i + 1) % 4] ^ m13[(i + 2) % 4] ^ m9[(i + 3) % 4];
			end
		end
		return r;
	endfunction

	function automatic aesKey nextRoundKey(input aesKey k, input logic [7:0] rcon);
		aesKey r;
		logic [0:3][7:0] t;
		// RotWord and SubWord on the last word
		t[0] = sBox[k[13]] ^ rcon;
		t[1] = sBox[k[14]];
		t[2] = sBox[k[15]];
		t[3] = sBox[k[12]];
		r[0:3] = k[0:3] ^ t;
		r[4:7] = k[4:7] ^ r[0:3];
		r[8:11] = k[8:11] ^ r[4:7];
		r[12:15] = k[12:15] ^ r[8:11];
		return r;
	endfunction

endpackage

`default_nettype wire

//--- rtl/aesRoundEngine.sv
`timescale 1ns/10ps
`default_nettype none

module aesRoundEngine (
	input logic clock,
	input logic reset,
	input logic keysReady,
	input logic decrypt,
	input aesPkg::aesBlock dataIn,
	input aesPkg::aesKey roundKey,
	output aesPkg::roundIndex keyIndex,
	output aesPkg::aesBlock dataOut,
	output logic blockDone
);
	import aesPkg::*;

	localparam roundIndex lastRound = roundIndex'(numRounds);

	logic running;
	roundIndex round;
	aesBlock state;
	aesBlock encNext;
	aesBlock decNext;

	// Round stays 0 while idle, so the first key is 0 or 10
	assign keyIndex = decrypt ? lastRound - round : round;

	always_comb
	begin
		encNext = shiftRows(subBytes(state));
		if (round != lastRound)
		begin
			encNext = mixColumns(encNext);
		end
		encNext = encNext ^ roundKey;

		decNext = invSubBytes(invShiftRows(state)) ^ roundKey;
		if (round != lastRound)
		begin
			decNext = invMixColumns(decNext);
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			running <= 1'b0;
			round <= '0;
			blockDone <= 1'b0;
		end
		else
		begin
			blockDone <= 1'b0;
			if (!running && keysReady)
			begin
				running <= 1'b1;
				round <= roundIndex'(1);
			end
			else if (running)
			begin
				if (round == lastRound)
				begin
					running <= 1'b0;
					round <= '0;
					blockDone <= 1'b1;
				end
				else
				begin
					round <= round + 1'b1;
				end
			end
		end
	end

	// Initial AddRoundKey, then one full round per cycle
	always_ff @(posedge clock)
	begin
		if (!running && keysReady)
		begin
			state <= dataIn ^ roundKey;
		end
		else if (running)
		begin
			state <= decrypt ? decNext : encNext;
		end
	end

	assign dataOut = state;

endmodule

`default_nettype wire

//--- rtl/apbPkg.sv
`default_nettype none

package apbPkg;

	typedef logic [7:0] apbAddr;
	typedef logic [31:0] apbData;

	typedef struct packed {
		apbAddr paddr;
		logic psel;
		logic penable;
		logic pwrite;
		apbData pwdata;
	} apbReq;

	typedef struct packed {
		apbData prdata;
		logic pready;
		logic pslverr;
	} apbRsp;

	// Word 0 of each 128-bit value is its top 32 bits
	localparam apbAddr keyBase = 8'h00;
	localparam apbAddr dataBase = 8'h10;
	localparam apbAddr resultBase = 8'h20;
	localparam apbAddr ctrlAddr = 8'h30;
	localparam apbAddr statusAddr = 8'h34;

	localparam int ctrlStartBit = 0;
	localparam int ctrlDecryptBit = 1;
	localparam int statusBusyBit = 0;
	localparam int statusDoneBit = 1;

endpackage

`default_nettype wire

//--- tests/aesCoreTbTasks.svh
`ifndef AES_CORE_TB_TASKS_SVH
`define AES_CORE_TB_TASKS_SVH

task automatic checkValue(input string what, input logic [127:0] expected,
	input logic [127:0] actual);
	checkCount++;
	assert (actual === expected)
	else
	begin
		$display("CHECK FAILED %s %s: expected %h actual %h", testName, what, expected, actual);
		errorCount++;
	end
endtask

task automatic checkBusError(input apbAddr addr, input logic expected, input logic actual);
	checkCount++;
	assert (actual === expected)
	else
	begin
		if (actual)
			$display("%s: unexpected bus error on access to address %h", testName, addr);
		else
			$display("%s: missing bus error on access to address %h", testName, addr);
		errorCount++;
	end
endtask

// Setup cycle, then access cycle; response sampled mid access
task automatic apbAccess(input logic write, input apbAddr addr, input apbData wdata,
	output apbData rdata, output logic err);
	@(posedge clock);
	#1;
	busReq = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: write, pwdata: wdata};
	@(posedge clock);
	#1;
	busReq.penable = 1'b1;
	@(negedge clock);
	rdata = busRsp.prdata;
	err = busRsp.pslverr;
	checkCount++;
	assert (busRsp.pready === 1'b1)
	else
	begin
		$display("%s: pready was low in the access cycle at address %h", testName, addr);
		errorCount++;
	end
	@(posedge clock);
	#1;
	busReq = '0;
endtask

task automatic apbWrite(input apbAddr addr, input apbData data, input logic expectErr);
	apbData ignored;
	logic err;
	apbAccess(1'b1, addr, data, ignored, err);
	checkBusError(addr, expectErr, err);
endtask

task automatic apbRead(input apbAddr addr, output apbData data, input logic expectErr);
	logic err;
	apbAccess(1'b0, addr, '0, data, err);
	checkBusError(addr, expectErr, err);
endtask

// Word 0 carries the top 32 bits
task automatic loadBlock(input apbAddr base, input logic [127:0] value);
	for (int w = 0; w < 4; w++)
	begin
		apbWrite(base + apbAddr'(4 * w), value[127 - 32 * w -: 32], 1'b0);
	end
endtask

task automatic readBlock(input apbAddr base, output logic [127:0] value);
	apbData word;
	for (int w = 0; w < 4; w++)
	begin
		apbRead(base + apbAddr'(4 * w), word, 1'b0);
		value[127 - 32 * w -: 32] = word;
	end
endtask

`endif

//--- tests/aesCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module aesCoreTb;
	import apbPkg::*;

	logic clock;
	logic reset;
	apbPkg::apbReq busReq;
	apbPkg::apbRsp busRsp;
	logic doneOut;
	string testName;
	int errorCount;
	int checkCount;
	int cycleCount = 0;

	aesCore UUT (
		.clock(clock),
		.reset(reset),
		.apbReq(busReq),
		.apbRsp(busRsp),
		.done(doneOut)
	);

	`include "aesCoreTbTasks.svh"

	always #20 clock = ~clock;

	always @(posedge clock)
		cycleCount++;

	function automatic logic [127:0] randomBlock();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// Poll status until done, bounded by 100 clock cycles
	task automatic waitDone();
		int startCycle;
		apbData status;
		logic finished;
		startCycle = cycleCount;
		finished = 1'b0;
		while (!finished && cycleCount - startCycle < 100)
		begin
			apbRead(statusAddr, status, 1'b0);
			finished = status[statusDoneBit];
		end
		if (!finished)
		begin
			$display("%s: timeout, done was not set within 100 cycles", testName);
			errorCount++;
		end
	endtask

	task automatic runBlock(input logic [127:0] key, input logic [127:0] data,
		input logic dec, output logic [127:0] result);
		apbData ctrl;
		ctrl = '0;
		ctrl[ctrlStartBit] = 1'b1;
		ctrl[ctrlDecryptBit] = dec;
		loadBlock(keyBase, key);
		loadBlock(dataBase, data);
		apbWrite(ctrlAddr, ctrl, 1'b0);
		waitDone();
		readBlock(resultBase, result);
	endtask

	task automatic testRegisters();
		logic [127:0] key;
		logic [127:0] data;
		logic [127:0] readBack;
		apbData status;
		testName = "registers";
		apbRead(statusAddr, status, 1'b0);
		checkValue("status after reset", 0, status);
		readBlock(resultBase, readBack);
		checkValue("result after reset", 0, readBack);
		key = randomBlock();
		data = randomBlock();
		loadBlock(keyBase, key);
		loadBlock(dataBase, data);
		readBlock(keyBase, readBack);
		checkValue("key readback", key, readBack);
		readBlock(dataBase, readBack);
		checkValue("data readback", data, readBack);
		apbWrite(ctrlAddr, 32'h1, 1'b0);
		apbRead(statusAddr, status, 1'b0);
		checkValue("busy after start", 1, status[statusBusyBit]);
		checkValue("done after start", 0, status[statusDoneBit]);
		waitDone();
		apbRead(statusAddr, status, 1'b0);
		checkValue("busy at end", 0, status[statusBusyBit]);
		checkValue("done at end", 1, status[statusDoneBit]);
		checkValue("done pin", 1, doneOut);
	endtask

	task automatic testEncryptVector();
		logic [127:0] result;
		testName = "encrypt vector";
		runBlock(128'h000102030405060708090a0b0c0d0e0f,
			128'h00112233445566778899aabbccddeeff, 1'b0, result);
		checkValue("ciphertext", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, result);
	endtask

	task automatic testDecryptVector();
		logic [127:0] result;
		testName = "decrypt vector";
		runBlock(128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h3925841d02dc09fbdc118597196a0b32, 1'b1, result);
		checkValue("plaintext", 128'h3243f6a8885a308d313198a2e0370734, result);
	endtask

	task automatic testRoundTrip();
		logic [127:0] key;
		logic [127:0] plain;
		logic [127:0] cipher;
		logic [127:0] result;
		testName = "round trip";
		for (int i = 0; i < 8; i++)
		begin
			key = randomBlock();
			plain = randomBlock();
			runBlock(key, plain, 1'b0, cipher);
			runBlock(key, cipher, 1'b1, result);
			checkValue("decrypted block", plain, result);
		end
	endtask

	task automatic testBusErrors();
		logic [127:0] result;
		apbData ignored;
		testName = "bus errors";
		apbWrite(resultBase, 32'h12345678, 1'b1);
		apbWrite(resultBase + 8'h0c, 32'h9abcdef0, 1'b1);
		apbWrite(statusAddr, 32'h0, 1'b1);
		apbWrite(8'h40, 32'h0, 1'b1);
		apbRead(8'h40, ignored, 1'b1);
		loadBlock(keyBase, 128'h000102030405060708090a0b0c0d0e0f);
		loadBlock(dataBase, 128'h00112233445566778899aabbccddeeff);
		apbWrite(ctrlAddr, 32'h1, 1'b0);
		// Rejected while the block is in flight
		apbWrite(dataBase, 32'hdeadbeef, 1'b1);
		waitDone();
		readBlock(resultBase, result);
		checkValue("result after busy write", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, result);
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		busReq = '0;
		errorCount = 0;
		checkCount = 0;
		testName = "reset";
		void'($urandom(32'hea3ecf6a));
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		testRegisters();
		testEncryptVector();
		testDecryptVector();
		testRoundTrip();
		testBusErrors();
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
